// File: Makefile
RTL = common/clock_pkg.sv common/display_pkg.sv source/tick_gen.sv \
	control/button_cond.sv control/mode_ctrl.sv timekeeping/time_counter.sv \
	timekeeping/alarm_match.sv display/seg_scan.sv source/clock_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module tb_clock_top -f tb.f -Mdir obj_dir

run: build
	./obj_dir/Vtb_clock_top | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module clock_top $(RTL)

clean:
	rm -rf obj_dir sim.log

// File: common/clock_pkg.sv
package clock_pkg;

	// one time field, wide enough for 0..59
	typedef logic [5:0] field_t;

	localparam field_t SEC_MAX = 6'd59;	// last second
	localparam field_t MIN_MAX = 6'd59;	// last minute
	localparam field_t HR_MAX  = 6'd23;	// last hour of the day

	// top-level operating mode
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,	// normal timekeeping
		MODE_SETUP = 2'b01,	// clock halted, fields editable
		MODE_ALARM = 2'b10	// alarm time editable, clock runs
	} mode_t;

	// field picked for editing
	typedef enum logic [1:0] {
		POS_SEC = 2'b00,
		POS_MIN = 2'b01,
		POS_HR  = 2'b10
	} pos_t;

	localparam int BLINK_SCANS = 64;	// scan strobes per blink half-period

endpackage

// File: common/display_pkg.sv
package display_pkg;

	localparam int NUM_DIGITS = 6;	// hh mm ss

	typedef logic [3:0] digit_t;			// one decimal digit
	typedef logic [6:0] seg_t;			// {a, b, c, d, e, f, g}
	typedef logic [NUM_DIGITS-1:0] enb_t;	// active-low digit enables

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// segment pattern for one digit, blank outside 0..9
	function automatic seg_t seg_of_digit(input digit_t d);
		case (d)
			4'd0: return 7'b111_1110;
			4'd1: return 7'b011_0000;
			4'd2: return 7'b110_1101;
			4'd3: return 7'b111_1001;
			4'd4: return 7'b011_0011;
			4'd5: return 7'b101_1011;
			4'd6: return 7'b101_1111;
			4'd7: return 7'b111_0000;
			4'd8: return 7'b111_1111;
			4'd9: return 7'b111_0011;
			default: return SEG_BLANK;
		endcase
	endfunction

endpackage

// File: control/button_cond.sv
`timescale 1ns/1ps

module button_cond (
	input  logic clk,
	input  logic rst_n,
	input  logic i_scan_tick,
	input  logic i_btn,
	output logic o_press
);

	logic samp_cur;		// latest scan sample
	logic samp_prev;	// sample from the scan before

	// --------------------------------------------------
	// slow sampling, bounce shorter than a scan is lost
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_cur  <= 1'b0;
			samp_prev <= 1'b0;
		end else if (i_scan_tick) begin
			samp_cur  <= i_btn;
			samp_prev <= samp_cur;
		end
	end

	// rising edge between two samples, one clock wide
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_press <= 1'b0;
		end else begin
			o_press <= i_scan_tick & samp_cur & ~samp_prev;
		end
	end

endmodule

// File: control/mode_ctrl.sv
`timescale 1ns/1ps

module mode_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sec_tick,
	input  logic              i_press_mode,
	input  logic              i_press_pos,
	input  logic              i_press_inc,
	input  logic              i_press_alarm,
	output clock_pkg::mode_t  o_mode,
	output clock_pkg::pos_t   o_pos,
	output logic              o_alarm_en,
	output logic              o_clk_inc_sec,
	output logic              o_clk_inc_min,
	output logic              o_clk_inc_hr,
	output logic              o_alm_inc_sec,
	output logic              o_alm_inc_min,
	output logic              o_alm_inc_hr
);
	import clock_pkg::*;

	logic inc_at_sec;	// increment press aimed at each field
	logic inc_at_min;
	logic inc_at_hr;

	// --------------------------------------------------
	// mode, position and alarm enable
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press_mode) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pos <= POS_SEC;
		end else if (i_press_pos) begin
			case (o_pos)
				POS_SEC: o_pos <= POS_MIN;
				POS_MIN: o_pos <= POS_HR;
				default: o_pos <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press_alarm) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// --------------------------------------------------
	// increment steering
	// --------------------------------------------------
	assign inc_at_sec = i_press_inc && (o_pos == POS_SEC);
	assign inc_at_min = i_press_inc && (o_pos == POS_MIN);
	assign inc_at_hr  = i_press_inc && (o_pos == POS_HR);

	always_comb begin
		o_clk_inc_sec = 1'b0;
		o_clk_inc_min = 1'b0;
		o_clk_inc_hr  = 1'b0;
		o_alm_inc_sec = 1'b0;
		o_alm_inc_min = 1'b0;
		o_alm_inc_hr  = 1'b0;
		case (o_mode)
			MODE_SETUP: begin	// second strobe held back
				o_clk_inc_sec = inc_at_sec;
				o_clk_inc_min = inc_at_min;
				o_clk_inc_hr  = inc_at_hr;
			end
			MODE_ALARM: begin
				o_clk_inc_sec = i_sec_tick;
				o_alm_inc_sec = inc_at_sec;
				o_alm_inc_min = inc_at_min;
				o_alm_inc_hr  = inc_at_hr;
			end
			default: o_clk_inc_sec = i_sec_tick;
		endcase
	end

endmodule

// File: display/seg_scan.sv
`timescale 1ns/1ps

module seg_scan (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_scan_tick,
	input  clock_pkg::mode_t   i_mode,
	input  clock_pkg::pos_t    i_pos,
	input  clock_pkg::field_t  i_clk_sec,
	input  clock_pkg::field_t  i_clk_min,
	input  clock_pkg::field_t  i_clk_hr,
	input  clock_pkg::field_t  i_alm_sec,
	input  clock_pkg::field_t  i_alm_min,
	input  clock_pkg::field_t  i_alm_hr,
	output display_pkg::seg_t  o_seg,
	output display_pkg::enb_t  o_seg_enb
);
	import clock_pkg::*;
	import display_pkg::*;

	localparam int IDX_W   = $clog2(NUM_DIGITS);
	localparam int BLINK_W = $clog2(BLINK_SCANS);

	field_t show_sec;
	field_t show_min;
	field_t show_hr;
	digit_t digits [NUM_DIGITS];	// 0 = sec ones ... 5 = hr tens
	logic [IDX_W-1:0] scan_idx;		// active digit
	logic [BLINK_W-1:0] blink_cnt;
	logic blink_off;			// blank half of the blink
	logic editing;
	logic blank;

	// --------------------------------------------------
	// time select and digit split
	// --------------------------------------------------
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			show_sec = i_alm_sec;
			show_min = i_alm_min;
			show_hr  = i_alm_hr;
		end else begin
			show_sec = i_clk_sec;
			show_min = i_clk_min;
			show_hr  = i_clk_hr;
		end
	end

	always_comb begin
		digits[0] = digit_t'(show_sec % 10);
		digits[1] = digit_t'(show_sec / 10);
		digits[2] = digit_t'(show_min % 10);
		digits[3] = digit_t'(show_min / 10);
		digits[4] = digit_t'(show_hr % 10);
		digits[5] = digit_t'(show_hr / 10);
	end

	// --------------------------------------------------
	// digit scan and blink timing
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == IDX_W'(NUM_DIGITS - 1)) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blink_cnt <= '0;
			blink_off <= 1'b0;
		end else if (i_scan_tick) begin
			if (blink_cnt == BLINK_W'(BLINK_SCANS - 1)) begin
				blink_cnt <= '0;
				blink_off <= ~blink_off;
			end else begin
				blink_cnt <= blink_cnt + 1'b1;
			end
		end
	end

	// digit pair index matches the pos encoding
	assign editing = (i_mode == MODE_SETUP) || (i_mode == MODE_ALARM);
	assign blank   = editing && blink_off &&
			 (scan_idx[IDX_W-1:1] == (IDX_W-1)'(i_pos));

	// segments and enable leave on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= SEG_BLANK;
			o_seg_enb <= ~enb_t'(1);
		end else begin
			o_seg     <= blank ? SEG_BLANK : seg_of_digit(digits[scan_idx]);
			o_seg_enb <= ~(enb_t'(1) << scan_idx);
		end
	end

endmodule

// File: sim/tb_clock_top.sv
`timescale 1ns/1ps

module tb_clock_top;
	import clock_pkg::*;
	import display_pkg::*;

	localparam int CLK_PER_SEC  = 400;
	localparam int CLK_PER_SCAN = 4;
	localparam int PRESS_CLKS   = 12 * CLK_PER_SCAN;	// held this long then released as long
	localparam int MAX_CYCLES   = 200_000;	// about four full runs
	localparam int DAY_SECS     = 86_400;
	localparam int BTN_MODE     = 0;
	localparam int BTN_POS      = 1;
	localparam int BTN_INC      = 2;
	localparam int BTN_ALARM    = 3;

	logic clk;
	logic rst_n;
	logic btn_mode;
	logic btn_pos;
	logic btn_inc;
	logic btn_alarm;
	seg_t seg;
	enb_t seg_enb;
	logic alarm;
	int errors;
	int checks;
	int cycles;

	clock_top #(
		.CLK_PER_SEC	(CLK_PER_SEC),
		.CLK_PER_SCAN	(CLK_PER_SCAN)
	) i_clock_top (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_mode	(btn_mode),
		.i_btn_pos	(btn_pos),
		.i_btn_inc	(btn_inc),
		.i_btn_alarm	(btn_alarm),
		.o_seg		(seg),
		.o_seg_enb	(seg_enb),
		.o_alarm	(alarm)
	);

	always #50 clk = ~clk;	// 100 ns period

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic finish_run();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	function automatic int day_secs(input int h, input int m, input int s);
		return (h * 3600 + m * 60 + s) % DAY_SECS;
	endfunction

	// seconds from a to b across midnight
	function automatic int elapsed(input int a, input int b);
		return (b - a + DAY_SECS) % DAY_SECS;
	endfunction

	task automatic set_btn(input int which, input logic val);
		case (which)
			BTN_MODE: btn_mode = val;
			BTN_POS:  btn_pos = val;
			BTN_INC:  btn_inc = val;
			default:  btn_alarm = val;
		endcase
	endtask

	task automatic press(input int which, input int times);
		repeat (times) begin
			@(negedge clk);
			set_btn(which, 1'b1);
			repeat (PRESS_CLKS) @(negedge clk);
			set_btn(which, 1'b0);
			repeat (PRESS_CLKS) @(negedge clk);
		end
	endtask

	// one full scan decoded back to numbers
	task automatic read_display(output int h, output int m, output int s, output bit ok);
		seg_t pat [NUM_DIGITS];
		int val [NUM_DIGITS];
		enb_t seen;
		int i;
		int d;
		seen = '0;
		ok = 1'b1;
		while (seen != '1) begin
			@(negedge clk);
			for (i = 0; i < NUM_DIGITS; i++) begin
				if (!seg_enb[i]) begin
					pat[i] = seg;
					seen[i] = 1'b1;
				end
			end
		end
		for (i = 0; i < NUM_DIGITS; i++) begin
			val[i] = -1;
			for (d = 0; d < 10; d++) begin
				if (seg_of_digit(digit_t'(d)) == pat[i]) begin
					val[i] = d;
				end
			end
			if (val[i] < 0) begin
				ok = 1'b0;
			end
		end
		h = val[5] * 10 + val[4];
		m = val[3] * 10 + val[2];
		s = val[1] * 10 + val[0];
	endtask

	// retries until two readable scans in a row agree
	task automatic steady_time(input string name, output int h, output int m, output int s);
		int h1;
		int m1;
		int s1;
		bit ok1;
		bit ok2;
		bit same;
		int tries;
		tries = 0;
		do begin
			read_display(h1, m1, s1, ok1);
			read_display(h, m, s, ok2);
			same = ok1 && ok2 && h1 == h && m1 == m && s1 == s;
			tries++;
		end while (!same && tries < 40);
		if (!ok2) begin
			$display("%s: a digit pattern on the display matches no decimal digit", name);
			errors++;
		end else if (!same) begin
			$display("%s: display never showed the same time twice", name);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic after_reset();
		int h;
		int m;
		int s;
		steady_time("after reset", h, m, s);
		check("after reset time", 0, day_secs(h, m, s));
		check("after reset alarm", 0, int'(alarm));
	endtask

	task automatic time_runs();
		int h;
		int m;
		int s;
		int t1;
		int diff;
		int blanks;
		int bad_enb;
		steady_time("time runs", h, m, s);
		t1 = day_secs(h, m, s);
		blanks = 0;
		bad_enb = 0;
		repeat (5 * CLK_PER_SEC) begin	// no blanking in clock mode
			@(negedge clk);
			if (seg == SEG_BLANK) begin
				blanks++;
			end
			if ($countones(~seg_enb) != 1) begin
				bad_enb++;
			end
		end
		steady_time("time runs", h, m, s);
		diff = elapsed(t1, day_secs(h, m, s));
		check("time runs seconds", 5, (diff >= 4 && diff <= 6) ? 5 : diff);
		check("time runs blank digit cycles", 0, blanks);
		check("time runs bad enable cycles", 0, bad_enb);
	endtask

	task automatic setup_rollover();
		int h0;
		int m0;
		int s0;
		int h;
		int m;
		int s;
		press(BTN_MODE, 1);	// clock -> setup
		steady_time("setup freeze", h0, m0, s0);
		repeat (2 * CLK_PER_SEC) @(negedge clk);
		steady_time("setup freeze", h, m, s);
		check("setup freeze", day_secs(h0, m0, s0), day_secs(h, m, s));
		press(BTN_POS, 2);	// sec -> min -> hr
		press(BTN_INC, 25);
		steady_time("setup rollover", h, m, s);
		check("setup minutes kept", m0, m);
		check("setup seconds kept", s0, s);
		press(BTN_MODE, 2);	// via alarm back to clock
		steady_time("setup rollover", h, m, s);
		check("setup hours rollover", (h0 + 25) % 24, h);
	endtask

	task automatic blink_edit_pair();
		enb_t was_blank;
		int i;
		press(BTN_MODE, 1);	// clock -> setup
		press(BTN_POS, 2);	// hr -> sec -> min
		was_blank = '0;
		repeat (4 * BLINK_SCANS * CLK_PER_SCAN) begin
			@(negedge clk);
			for (i = 0; i < NUM_DIGITS; i++) begin
				if (!seg_enb[i] && seg == SEG_BLANK) begin
					was_blank[i] = 1'b1;
				end
			end
		end
		for (i = 0; i < NUM_DIGITS; i++) begin
			check($sformatf("blink digit %0d", i), int'(i == 2 || i == 3), int'(was_blank[i]));
		end
	endtask

	task automatic alarm_edit();
		int h0;
		int m0;
		int s0;
		int h;
		int m;
		int s;
		int adv;
		steady_time("alarm edit", h0, m0, s0);	// still frozen in setup
		press(BTN_MODE, 1);	// setup -> alarm
		press(BTN_POS, 2);	// min -> hr -> sec
		press(BTN_INC, 7);
		steady_time("alarm edit", h, m, s);
		check("alarm edit time", day_secs(0, 0, 7), day_secs(h, m, s));
		press(BTN_MODE, 1);	// alarm -> clock
		steady_time("alarm edit", h, m, s);
		adv = elapsed(day_secs(h0, m0, s0), day_secs(h, m, s));
		check("alarm edit clock advanced", 1, (adv > 0) ? 1 : adv);
	endtask

	task automatic alarm_level();
		int h;
		int m;
		int s;
		int alm_h;
		int alm_m;
		int alm_s;
		int target;
		int n;
		press(BTN_MODE, 1);	// into setup so the clock halts
		steady_time("alarm level", h, m, s);
		target = (day_secs(h, m, s) + 60) % DAY_SECS;	// covers the editing time
		press(BTN_MODE, 1);	// setup -> alarm
		steady_time("alarm level", alm_h, alm_m, alm_s);
		press(BTN_INC, (target % 60 - alm_s + 60) % 60);	// may carry into minutes
		steady_time("alarm level", alm_h, alm_m, alm_s);
		press(BTN_POS, 1);
		press(BTN_INC, ((target / 60) % 60 - alm_m + 60) % 60);
		press(BTN_POS, 1);
		press(BTN_INC, (target / 3600 - alm_h + 24) % 24);
		press(BTN_POS, 1);	// back to sec
		steady_time("alarm level", alm_h, alm_m, alm_s);
		check("alarm level alarm time", target, day_secs(alm_h, alm_m, alm_s));
		press(BTN_MODE, 1);	// alarm -> clock
		do begin
			steady_time("alarm level", h, m, s);
		end while (elapsed(day_secs(h, m, s), target) > 3);
		press(BTN_ALARM, 1);	// enable
		n = 0;
		while (!alarm && n < 5 * CLK_PER_SEC) begin
			@(negedge clk);
			n++;
		end
		check("alarm level rise", 1, int'(alarm));
		steady_time("alarm level", h, m, s);
		check("alarm level display", target, day_secs(h, m, s));
		n = 0;
		repeat (CLK_PER_SEC) begin
			@(negedge clk);
			n += int'(!alarm);
		end
		check("alarm level held low cycles", 0, n);
		press(BTN_ALARM, 1);	// disable
		check("alarm level cleared", 0, int'(alarm));
		n = 0;
		repeat (2 * CLK_PER_SEC) begin
			@(negedge clk);
			n += int'(alarm);
		end
		check("alarm level stays low high cycles", 0, n);
	endtask

	// --------------------------------------------------
	// run control
	// --------------------------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			errors++;
			finish_run();
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		btn_mode = 1'b0;
		btn_pos = 1'b0;
		btn_inc = 1'b0;
		btn_alarm = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		after_reset();
		time_runs();
		setup_rollover();
		blink_edit_pair();
		alarm_edit();
		alarm_level();
		finish_run();
	end

endmodule

// File: source/clock_top.sv
`timescale 1ns/1ps

module clock_top #(
	parameter int CLK_PER_SEC  = 50_000_000,
	parameter int CLK_PER_SCAN = 50_000
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_btn_mode,
	input  logic               i_btn_pos,
	input  logic               i_btn_inc,
	input  logic               i_btn_alarm,
	output display_pkg::seg_t  o_seg,
	output display_pkg::enb_t  o_seg_enb,
	output logic               o_alarm
);
	import clock_pkg::*;

	logic sec_tick;
	logic scan_tick;
	logic press_mode;
	logic press_pos;
	logic press_inc;
	logic press_alarm;
	mode_t mode;
	pos_t pos;
	logic alarm_en;
	logic clk_inc_sec;
	logic clk_inc_min;
	logic clk_inc_hr;
	logic alm_inc_sec;
	logic alm_inc_min;
	logic alm_inc_hr;
	field_t clk_sec;
	field_t clk_min;
	field_t clk_hr;
	field_t alm_sec;
	field_t alm_min;
	field_t alm_hr;

	// --------------------------------------------------
	// strobes
	// --------------------------------------------------
	tick_gen #(.DIV(CLK_PER_SEC)) u_sec_tick (
		.clk	(clk),
		.rst_n	(rst_n),
		.o_tick	(sec_tick)
	);

	tick_gen #(.DIV(CLK_PER_SCAN)) u_scan_tick (
		.clk	(clk),
		.rst_n	(rst_n),
		.o_tick	(scan_tick)
	);

	// --------------------------------------------------
	// buttons
	// --------------------------------------------------
	button_cond u_btn_mode (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_tick	(scan_tick),
		.i_btn		(i_btn_mode),
		.o_press	(press_mode)
	);

	button_cond u_btn_pos (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_tick	(scan_tick),
		.i_btn		(i_btn_pos),
		.o_press	(press_pos)
	);

	button_cond u_btn_inc (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_tick	(scan_tick),
		.i_btn		(i_btn_inc),
		.o_press	(press_inc)
	);

	button_cond u_btn_alarm (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_tick	(scan_tick),
		.i_btn		(i_btn_alarm),
		.o_press	(press_alarm)
	);

	// --------------------------------------------------
	// control and time
	// --------------------------------------------------
	mode_ctrl u_mode_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_sec_tick	(sec_tick),
		.i_press_mode	(press_mode),
		.i_press_pos	(press_pos),
		.i_press_inc	(press_inc),
		.i_press_alarm	(press_alarm),
		.o_mode		(mode),
		.o_pos		(pos),
		.o_alarm_en	(alarm_en),
		.o_clk_inc_sec	(clk_inc_sec),
		.o_clk_inc_min	(clk_inc_min),
		.o_clk_inc_hr	(clk_inc_hr),
		.o_alm_inc_sec	(alm_inc_sec),
		.o_alm_inc_min	(alm_inc_min),
		.o_alm_inc_hr	(alm_inc_hr)
	);

	time_counter u_clock_time (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_inc_sec	(clk_inc_sec),
		.i_inc_min	(clk_inc_min),
		.i_inc_hr	(clk_inc_hr),
		.o_sec		(clk_sec),
		.o_min		(clk_min),
		.o_hr		(clk_hr)
	);

	time_counter u_alarm_time (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_inc_sec	(alm_inc_sec),
		.i_inc_min	(alm_inc_min),
		.i_inc_hr	(alm_inc_hr),
		.o_sec		(alm_sec),
		.o_min		(alm_min),
		.o_hr		(alm_hr)
	);

	alarm_match u_alarm_match (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_alarm_en	(alarm_en),
		.i_clk_sec	(clk_sec),
		.i_clk_min	(clk_min),
		.i_clk_hr	(clk_hr),
		.i_alm_sec	(alm_sec),
		.i_alm_min	(alm_min),
		.i_alm_hr	(alm_hr),
		.o_alarm	(o_alarm)
	);

	// --------------------------------------------------
	// display
	// --------------------------------------------------
	seg_scan u_seg_scan (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_scan_tick	(scan_tick),
		.i_mode		(mode),
		.i_pos		(pos),
		.i_clk_sec	(clk_sec),
		.i_clk_min	(clk_min),
		.i_clk_hr	(clk_hr),
		.i_alm_sec	(alm_sec),
		.i_alm_min	(alm_min),
		.i_alm_hr	(alm_hr),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb)
	);

endmodule

// File: source/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 50_000	// strobe period in clocks
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;	// one clock per period
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// File: tb.f
common/clock_pkg.sv
common/display_pkg.sv
source/tick_gen.sv
control/button_cond.sv
control/mode_ctrl.sv
timekeeping/time_counter.sv
timekeeping/alarm_match.sv
display/seg_scan.sv
source/clock_top.sv
sim/tb_clock_top.sv

// File: timekeeping/alarm_match.sv
`timescale 1ns/1ps

module alarm_match (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_alarm_en,
	input  clock_pkg::field_t  i_clk_sec,
	input  clock_pkg::field_t  i_clk_min,
	input  clock_pkg::field_t  i_clk_hr,
	input  clock_pkg::field_t  i_alm_sec,
	input  clock_pkg::field_t  i_alm_min,
	input  clock_pkg::field_t  i_alm_hr,
	output logic               o_alarm
);

	logic time_eq;

	assign time_eq = (i_clk_sec == i_alm_sec) &&
			 (i_clk_min == i_alm_min) &&
			 (i_clk_hr  == i_alm_hr);

	// latches on a match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (time_eq | o_alarm);
		end
	end

endmodule

// File: timekeeping/time_counter.sv
`timescale 1ns/1ps

module time_counter (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_inc_sec,
	input  logic               i_inc_min,
	input  logic               i_inc_hr,
	output clock_pkg::field_t  o_sec,
	output clock_pkg::field_t  o_min,
	output clock_pkg::field_t  o_hr
);
	import clock_pkg::*;

	logic carry_min;	// seconds step wraps 59 -> 0
	logic carry_hr;		// ... and minutes wrap with it
	logic step_min;
	logic step_hr;

	// advance one field, wrapping past its last value
	function automatic field_t bump(input field_t val, input field_t max_val);
		return (val == max_val) ? '0 : val + 6'd1;
	endfunction

	// --------------------------------------------------
	// carry chain, settles in the stepping cycle
	// --------------------------------------------------
	assign carry_min = i_inc_sec & (o_sec == SEC_MAX);
	assign carry_hr  = carry_min & (o_min == MIN_MAX);

	assign step_min = i_inc_min | carry_min;	// both at once count once
	assign step_hr  = i_inc_hr | carry_hr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hr  <= '0;
		end else begin
			if (i_inc_sec) begin
				o_sec <= bump(o_sec, SEC_MAX);
			end
			if (step_min) begin
				o_min <= bump(o_min, MIN_MAX);
			end
			if (step_hr) begin
				o_hr <= bump(o_hr, HR_MAX);	// day rollover
			end
		end
	end

endmodule
